// ==== src/zxclk_pkg.sv ====
package zxclk_pkg;

  // Width of the PLL option field
  localparam int pll_option_w = 3;

  // Width of the shared CPU clock divider
  localparam int div_cnt_w = 3;

  // CPU speed select, named after the resulting CPU clock rate
  typedef enum logic [1:0] {
    turbo_3m5 = 2'd0,  // Divide by 8
    turbo_7m  = 2'd1,  // Divide by 4
    turbo_14m = 2'd2,  // Divide by 2
    turbo_28m = 2'd3   // Divide by 1
  } turbo_t;

  // Requested settings from the core
  typedef struct packed {
    logic [pll_option_w-1:0] pll_option;
    turbo_t                  turbo;
  } clk_ctrl_t;

  // What the PLL currently reports
  typedef struct packed {
    logic [pll_option_w-1:0] pll_state;  // Option in effect
    logic                    locked;
    logic                    ready;      // Single-cycle pulse at relock
  } pll_status_t;

  // CPU clock bundle in the CLK_OUT1 domain
  typedef struct packed {
    logic ce;     // One-cycle enable
    logic level;  // Stretched during contention
    logic plain;  // Never stretched
  } cpu_clk_t;

  // Default timing of the reconfiguration path
  localparam int reconf_delay_default = 8;
  localparam int lock_cycles_default  = 16;

  // Divisor minus one, used as a bit mask on the divider count
  function automatic logic [div_cnt_w-1:0] turbo_mask(input turbo_t sel);
    return div_cnt_w'((8 >> sel) - 1);
  endfunction

endpackage

// ==== src/reconf_sequencer.sv ====
`timescale 1ns/1ns

// Watches the requested PLL option and, after a fixed delay, issues a
// single reconfiguration step toward the PLL port.
// A step is also forced out after reset so the PLL boots into option 0.
module reconf_sequencer
  import zxclk_pkg::*;
#(
  parameter int RECONF_DELAY = reconf_delay_default
) (
  input  logic                    CLK_OUT1,
  input  logic                    rst,
  input  logic [pll_option_w-1:0] pll_option,
  output logic                    reconf_step,
  output logic [pll_option_w-1:0] pll_state
);

  // Seed value for the delay chain, a single one in bit 0
  localparam logic [RECONF_DELAY:0] chain_seed = {{RECONF_DELAY{1'b0}}, 1'b1};

  // Option last accepted from the core
  logic [pll_option_w-1:0] option_q;

  // Delay chain, the token walks up one bit per cycle
  // Bit RECONF_DELAY is reached RECONF_DELAY edges after the seed
  logic [RECONF_DELAY:0] step_chain;

  // Request differs from what is stored
  logic option_change;

  assign option_change = (pll_option != option_q);

  always_ff @(posedge CLK_OUT1) begin
    if (rst) begin
      // Boot state is option 0 with a step already on its way
      option_q   <= '0;
      step_chain <= chain_seed;
    end else if (option_change) begin
      // Store the new option and restart the delay
      // Any token still in flight is dropped here
      option_q   <= pll_option;
      step_chain <= chain_seed;
    end else begin
      step_chain <= {step_chain[RECONF_DELAY-1:0], 1'b0};
    end
  end

  // Far end of the chain is the step pulse
  // Only one token ever lives in the chain, so this is one cycle wide
  assign reconf_step = step_chain[RECONF_DELAY];

  // The PLL is told the option as soon as it is stored
  assign pll_state = option_q;

endmodule

// ==== src/pll_lock_model.sv ====
`timescale 1ns/1ns

// Behavioural stand-in for the PLL and its reconfiguration port.
// A step drops lock, a relock counter runs for LOCK_CYCLES cycles,
// then lock returns together with a one-cycle ready pulse.
module pll_lock_model
  import zxclk_pkg::*;
#(
  parameter int LOCK_CYCLES = lock_cycles_default
) (
  input  logic                    CLK_OUT1,
  input  logic                    rst,
  input  logic                    reconf_step,
  input  logic [pll_option_w-1:0] pll_state,
  output pll_status_t             status
);

  // Enough bits to hold LOCK_CYCLES - 1
  localparam int cnt_w = (LOCK_CYCLES > 1) ? $clog2(LOCK_CYCLES) : 1;

  // Cycles left before lock returns, counts down to zero
  logic [cnt_w-1:0] relock_cnt;

  // High while a relock is in progress
  logic relocking;

  // Status fields as registers
  logic [pll_option_w-1:0] state_q;
  logic                    locked;
  logic                    ready;

  always_ff @(posedge CLK_OUT1) begin
    if (rst) begin
      // No lock until the boot step has been taken
      relock_cnt <= '0;
      relocking  <= 1'b0;
      state_q    <= '0;
      locked     <= 1'b0;
      ready      <= 1'b0;
    end else begin
      // ready is a pulse, cleared unless set below
      ready <= 1'b0;
      if (reconf_step) begin
        // New configuration, lock is lost at this edge
        // A step during a relock simply restarts the count
        relock_cnt <= cnt_w'(LOCK_CYCLES - 1);
        relocking  <= 1'b1;
        state_q    <= pll_state;
        locked     <= 1'b0;
      end else if (relocking) begin
        if (relock_cnt == '0) begin
          // Lock returns and the port reports ready
          relocking <= 1'b0;
          locked    <= 1'b1;
          ready     <= 1'b1;
        end else begin
          relock_cnt <= relock_cnt - 1'b1;
        end
      end
    end
  end

  // Pack the status bundle
  assign status.pll_state = state_q;
  assign status.locked    = locked;
  assign status.ready     = ready;

endmodule

// ==== src/cpu_clock_divider.sv ====
`timescale 1ns/1ns

// CPU clock generation inside the CLK_OUT1 domain.
// One free-running 3-bit counter serves all four rates, the rate
// only changes at the counter wrap so plain never glitches.
// Output is a clock level plus a clock enable, no clock muxing.
module cpu_clock_divider
  import zxclk_pkg::*;
(
  input  logic     CLK_OUT1,
  input  logic     rst,
  input  turbo_t   turbo,
  input  logic     contention,
  input  logic     locked,
  output cpu_clk_t cpu
);

  // Shared divider count
  logic [div_cnt_w-1:0] div_cnt;
  logic [div_cnt_w-1:0] div_cnt_nxt;

  // Rate in effect and the rate for the next cycle
  turbo_t active_turbo;
  turbo_t active_turbo_nxt;

  // Counter at its wrap point, the only place a rate change is allowed
  logic at_wrap;

  // Registered CPU clock levels
  logic plain_q;
  logic plain_nxt;

  // Contention as seen by the clock, one cycle after the input
  logic cont_q;

  // Enable condition before suppression
  logic ce_slot;

  assign div_cnt_nxt = div_cnt + 1'b1;
  assign at_wrap     = (div_cnt == '1);

  // Pick up the requested rate only at the wrap
  assign active_turbo_nxt = at_wrap ? turbo : active_turbo;

  // Next plain level, taken from the counter value it will sit next to
  // All rates agree at count 0, so the switch point is clean
  always_comb begin
    case (active_turbo_nxt)
      turbo_3m5: plain_nxt = div_cnt_nxt[2];
      turbo_7m:  plain_nxt = div_cnt_nxt[1];
      turbo_14m: plain_nxt = div_cnt_nxt[0];
      // Full rate just flips every cycle
      default:   plain_nxt = ~plain_q;
    endcase
  end

  always_ff @(posedge CLK_OUT1) begin
    if (rst) begin
      // Slowest rate after reset, clock low
      div_cnt      <= '0;
      active_turbo <= turbo_3m5;
      plain_q      <= 1'b0;
      cont_q       <= 1'b0;
    end else begin
      div_cnt      <= div_cnt_nxt;
      active_turbo <= active_turbo_nxt;
      plain_q      <= plain_nxt;
      cont_q       <= contention;
    end
  end

  // Last cycle of each CPU period, i.e. count mod divisor == divisor - 1
  assign ce_slot = ((div_cnt & turbo_mask(active_turbo)) == turbo_mask(active_turbo));

  // CPU does not advance while stretched or while the PLL relocks
  assign cpu.ce = ce_slot & ~cont_q & locked;

  // Stretched clock is pulled high during contention
  assign cpu.level = plain_q | cont_q;

  // Unstretched copy for logic that must keep the true phase
  assign cpu.plain = plain_q;

endmodule

// ==== src/clock_generator.sv ====
`timescale 1ns/1ns

// Clock section of the core.
// Option changes go through the sequencer into the PLL model, the
// PLL lock state then gates the CPU clock enable from the divider.
module clock_generator
  import zxclk_pkg::*;
#(
  parameter int RECONF_DELAY = reconf_delay_default,
  parameter int LOCK_CYCLES  = lock_cycles_default
) (
  input  logic        CLK_OUT1,
  input  logic        rst,
  input  clk_ctrl_t   ctrl,
  input  logic        contention,
  output pll_status_t status,
  output cpu_clk_t    cpu
);

  // Step pulse toward the PLL port
  logic reconf_step;

  // Option the sequencer has stored
  logic [pll_option_w-1:0] pll_state;

  // Delayed step generation from the requested option
  reconf_sequencer #(
    .RECONF_DELAY (RECONF_DELAY)
  ) u_reconf_sequencer (
    .CLK_OUT1    (CLK_OUT1),
    .rst         (rst),
    .pll_option  (ctrl.pll_option),
    .reconf_step (reconf_step),
    .pll_state   (pll_state)
  );

  // PLL lock and ready behaviour
  pll_lock_model #(
    .LOCK_CYCLES (LOCK_CYCLES)
  ) u_pll_lock_model (
    .CLK_OUT1    (CLK_OUT1),
    .rst         (rst),
    .reconf_step (reconf_step),
    .pll_state   (pll_state),
    .status      (status)
  );

  // CPU clock, held off while the PLL is not locked
  cpu_clock_divider u_cpu_clock_divider (
    .CLK_OUT1   (CLK_OUT1),
    .rst        (rst),
    .turbo      (ctrl.turbo),
    .contention (contention),
    .locked     (status.locked),
    .cpu        (cpu)
  );

endmodule

// ==== sim/clock_generator_sva.sv ====
`timescale 1ns/1ns

// Concurrent checks on the PLL model and the CPU divider
// Bound twice, each instance enables only the rules that fit its host
module clock_generator_sva #(
  parameter bit lock_rules  = 1'b0,
  parameter bit clock_rules = 1'b0
) (
  input logic CLK_OUT1,
  input logic rst,
  input logic locked,
  input logic ready,
  input logic contention,
  input logic level,
  input logic ce
);

  // Count of assertion failures in this instance
  int failures = 0;

  if (lock_rules) begin : g_lock_rules
    // ready lasts a single cycle
    ready_one_cycle: assert property (
      @(posedge CLK_OUT1) disable iff (rst) ready |=> !ready
    ) else begin
      $error("ready stayed high for more than one cycle");
      failures++;
    end

    // ready only together with the rise of locked
    ready_at_lock_rise: assert property (
      @(posedge CLK_OUT1) disable iff (rst) ready |-> $rose(locked)
    ) else begin
      $error("ready pulsed without a rise of locked");
      failures++;
    end

    // Every relock is reported
    lock_rise_has_ready: assert property (
      @(posedge CLK_OUT1) disable iff (rst) $rose(locked) |-> ready
    ) else begin
      $error("locked rose without a ready pulse");
      failures++;
    end
  end

  if (clock_rules) begin : g_clock_rules
    // Stretched clock is high in the cycle after contention is sampled
    level_held_high: assert property (
      @(posedge CLK_OUT1) disable iff (rst) contention |=> level
    ) else begin
      $error("level low while contention is registered");
      failures++;
    end

    // CPU must not advance on an unlocked PLL
    no_ce_unlocked: assert property (
      @(posedge CLK_OUT1) disable iff (rst) !locked |-> !ce
    ) else begin
      $error("ce pulsed while the PLL was not locked");
      failures++;
    end
  end

endmodule

// Lock and ready rules on the PLL model
bind pll_lock_model clock_generator_sva #(
  .lock_rules (1'b1)
) u_lock_sva (
  .CLK_OUT1   (CLK_OUT1),
  .rst        (rst),
  .locked     (locked),
  .ready      (ready),
  .contention (1'b0),
  .level      (1'b0),
  .ce         (1'b0)
);

// Contention and enable rules on the divider
bind cpu_clock_divider clock_generator_sva #(
  .clock_rules (1'b1)
) u_clock_sva (
  .CLK_OUT1   (CLK_OUT1),
  .rst        (rst),
  .locked     (locked),
  .ready      (1'b0),
  .contention (contention),
  .level      (cpu.level),
  .ce         (cpu.ce)
);

// ==== sim/tb_clock_generator.sv ====
`timescale 1ns/1ns

// Testbench for the clock section
// Table rows run in order, a cycle model beside the DUT predicts every output
module tb_clock_generator
  import zxclk_pkg::*;
();

  // Reconfiguration timing of the DUT, default parameters
  localparam int reconf_delay = reconf_delay_default;
  localparam int lock_cycles  = lock_cycles_default;

  // Row kinds
  localparam int k_boot    = 0;
  localparam int k_rate    = 1;
  localparam int k_switch  = 2;
  localparam int k_reconf  = 3;
  localparam int k_restart = 4;
  localparam int k_cont    = 5;

  localparam int num_rows = 11;

  // A new rate is active well before this many cycles
  localparam int settle_cycles = 16;

  // option2_at of 8'hff means no second option change
  typedef struct packed {
    logic [2:0] kind;
    turbo_t     turbo;
    logic [2:0] option;
    logic [2:0] option2;
    logic [7:0] option2_at;
    logic [7:0] cont_start;
    logic [7:0] cont_len;
    logic [7:0] cycles;
  } test_row_t;

  logic        CLK_OUT1;
  logic        rst;
  clk_ctrl_t   ctrl;
  logic        contention;
  pll_status_t status;
  cpu_clk_t    cpu;

  test_row_t tbl [num_rows];
  logic      table_ready;

  int     total_errors;
  int     pass_count;
  int     fail_count;
  int     sva_failures;
  logic   row_active;
  int     row_kind;
  int     row_div;
  int     row_min_half;
  int     cyc;
  turbo_t prev_turbo;

  // Statistics of the running row
  int first_high_cyc;
  int first_low_cyc;
  int low_count;
  int fall_count;
  int ready_count;
  int ce_in_low;
  int ce_late;
  int last_ce_cyc;
  int bad_interval;
  int stretch_seen;
  int stretch_exp;
  int ce_in_cont;
  int level_low_in_cont;
  int short_run;

  // Kept across rows
  logic prev_locked;
  logic plain_prev;
  int   plain_run;

  // Reference model state
  logic [2:0] m_cnt;
  turbo_t     m_act;
  logic       m_plain;
  logic       m_cont;
  logic [2:0] m_opt;
  int         m_since;
  logic       m_relock;
  int         m_age;
  logic       m_locked;
  logic       m_ready;
  logic [2:0] m_state;

  clock_generator dut (
    .CLK_OUT1   (CLK_OUT1),
    .rst        (rst),
    .ctrl       (ctrl),
    .contention (contention),
    .status     (status),
    .cpu        (cpu)
  );

  initial CLK_OUT1 = 1'b0;
  always #4 CLK_OUT1 = ~CLK_OUT1;

  // CPU clock divisor for each speed
  function automatic int divisor_of(input turbo_t t);
    case (t)
      turbo_3m5: return 8;
      turbo_7m:  return 4;
      turbo_14m: return 2;
      default:   return 1;
    endcase
  endfunction

  // Shortest run of one plain level at a speed
  function automatic int half_period_of(input turbo_t t);
    return (divisor_of(t) == 1) ? 1 : divisor_of(t) / 2;
  endfunction

  function automatic string kind_name(input int kind);
    case (kind)
      k_boot:    return "boot";
      k_rate:    return "rate";
      k_switch:  return "turbo switch";
      k_reconf:  return "reconfiguration";
      k_restart: return "restart";
      default:   return "contention";
    endcase
  endfunction

  function automatic test_row_t make_row(input int kind, input turbo_t t, input int opt,
                                         input int opt2, input int opt2_at, input int cs,
                                         input int cl, input int n);
    test_row_t row;
    row.kind       = 3'(kind);
    row.turbo      = t;
    row.option     = 3'(opt);
    row.option2    = 3'(opt2);
    row.option2_at = 8'(opt2_at);
    row.cont_start = 8'(cs);
    row.cont_len   = 8'(cl);
    row.cycles     = 8'(n);
    return row;
  endfunction

  task automatic fill_table();
    tbl[0]  = make_row(k_boot,    turbo_3m5, 0, 0, 255, 0, 0, 40);
    tbl[1]  = make_row(k_rate,    turbo_3m5, 0, 0, 255, 0, 0, 40);
    tbl[2]  = make_row(k_rate,    turbo_7m,  0, 0, 255, 0, 0, 40);
    tbl[3]  = make_row(k_rate,    turbo_14m, 0, 0, 255, 0, 0, 40);
    tbl[4]  = make_row(k_rate,    turbo_28m, 0, 0, 255, 0, 0, 40);
    tbl[5]  = make_row(k_switch,  turbo_3m5, 0, 0, 255, 0, 0, 32);
    tbl[6]  = make_row(k_switch,  turbo_7m,  0, 0, 255, 0, 0, 32);
    tbl[7]  = make_row(k_reconf,  turbo_7m,  5, 0, 255, 0, 0, 40);
    // Second change 3 cycles after the first
    tbl[8]  = make_row(k_restart, turbo_14m, 3, 6, 3, 0, 0, 44);
    // Contention start drawn at random
    tbl[9]  = make_row(k_cont, turbo_3m5, 6, 0, 255, 4 + ($urandom % 8), 10, 40);
    tbl[10] = make_row(k_cont, turbo_28m, 6, 0, 255, 4 + ($urandom % 8), 6, 32);
  endtask

  task automatic check_value(input string name, input logic signed [31:0] got,
                             input logic signed [31:0] exp);
    assert (got === exp) else begin
      $display("Error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
      total_errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      $display("Error at %0t ns: %s", $time, what);
      total_errors++;
    end
  endtask

  task automatic clear_stats();
    first_high_cyc    = -1;
    first_low_cyc     = -1;
    low_count         = 0;
    fall_count        = 0;
    ready_count       = 0;
    ce_in_low         = 0;
    ce_late           = 0;
    last_ce_cyc       = -1;
    bad_interval      = 0;
    stretch_seen      = 0;
    stretch_exp       = 0;
    ce_in_cont        = 0;
    level_low_in_cont = 0;
    short_run         = 0;
  endtask

  // Cycle model, built from the timing rules, sees the inputs the DUT samples
  always @(posedge CLK_OUT1) begin : ref_model
    int   d;
    logic step_now;
    if (rst) begin
      m_cnt    = '0;
      m_act    = turbo_3m5;
      m_plain  = 1'b0;
      m_cont   = 1'b0;
      m_opt    = '0;
      m_since  = 0;
      m_relock = 1'b0;
      m_age    = 0;
      m_locked = 1'b0;
      m_ready  = 1'b0;
      m_state  = '0;
    end else begin
      // Step is out RECONF_DELAY edges after the storing edge
      step_now = (m_since == reconf_delay);
      m_ready  = 1'b0;
      if (step_now) begin
        m_locked = 1'b0;
        m_relock = 1'b1;
        m_age    = 0;
        m_state  = m_opt;
      end else if (m_relock) begin
        m_age++;
        if (m_age == lock_cycles) begin
          m_locked = 1'b1;
          m_ready  = 1'b1;
          m_relock = 1'b0;
        end
      end
      if (ctrl.pll_option != m_opt) begin
        m_opt   = ctrl.pll_option;
        m_since = 0;
      end else if (m_since <= reconf_delay) begin
        m_since++;
      end
      // Rate changes only at the wrap
      if (m_cnt == 3'd7)
        m_act = ctrl.turbo;
      m_cnt = m_cnt + 3'd1;
      d = divisor_of(m_act);
      if (d == 1)
        m_plain = ~m_plain;
      else
        m_plain = ((m_cnt % d) >= d / 2);
      m_cont = contention;
    end
  end

  // Compare at the falling edge, where all outputs are settled
  always @(negedge CLK_OUT1) begin : compare_outputs
    int   d;
    logic exp_ce;
    d      = divisor_of(m_act);
    exp_ce = ((m_cnt % d) == d - 1) && !m_cont && m_locked;
    check_value("status.pll_state", status.pll_state, m_state);
    check_value("status.locked", status.locked, m_locked);
    check_value("status.ready", status.ready, m_ready);
    check_value("cpu.ce", cpu.ce, exp_ce);
    check_value("cpu.level", cpu.level, m_plain | m_cont);
    check_value("cpu.plain", cpu.plain, m_plain);
    if (row_active) begin
      if (status.locked) begin
        if (first_high_cyc < 0)
          first_high_cyc = cyc;
      end else begin
        low_count++;
        if (first_low_cyc < 0)
          first_low_cyc = cyc;
        if (cpu.ce)
          ce_in_low++;
      end
      if (prev_locked && !status.locked)
        fall_count++;
      if (status.ready)
        ready_count++;
      // Enable spacing once the new rate has settled
      if (cpu.ce && cyc >= settle_cycles) begin
        if (last_ce_cyc >= 0 && (cyc - last_ce_cyc) != row_div)
          bad_interval++;
        last_ce_cyc = cyc;
        ce_late++;
      end
      // Stretched cycles, level pulled high over a low plain
      if (cpu.level && !cpu.plain)
        stretch_seen++;
      if (m_cont && !m_plain)
        stretch_exp++;
      if (m_cont) begin
        if (cpu.ce)
          ce_in_cont++;
        if (!cpu.level)
          level_low_in_cont++;
      end
    end
    // Plain run lengths, the first run out of reset is not a real pulse
    if (cpu.plain === plain_prev) begin
      plain_run++;
    end else begin
      if (row_active && row_kind != k_boot && plain_run < row_min_half)
        short_run++;
      plain_run = 1;
    end
    plain_prev  = cpu.plain;
    prev_locked = status.locked;
  end

  task automatic evaluate_row(input int r);
    logic       second;
    logic [2:0] exp_opt;
    int         exp_start;
    second  = (tbl[r].option2_at != 8'hff);
    exp_opt = second ? tbl[r].option2 : tbl[r].option;
    // One edge to store the option, one for the PLL to see the step
    exp_start = reconf_delay + 2 + (second ? int'(tbl[r].option2_at) : 0);
    case (row_kind)
      k_boot: begin
        check_value("boot lock delay", first_high_cyc, reconf_delay + lock_cycles);
        check_value("ready pulses", ready_count, 1);
        check_value("status.pll_state", status.pll_state, 0);
      end
      k_rate, k_switch: begin
        check_value("ce interval errors", bad_interval, 0);
        check_true(ce_late >= 2, "too few ce pulses once the rate had settled");
      end
      k_reconf, k_restart: begin
        check_value("locked low cycles", low_count, lock_cycles);
        check_value("lock loss events", fall_count, 1);
        check_value("relock start cycle", first_low_cyc, exp_start);
        check_value("ready pulses", ready_count, 1);
        check_value("ce while unlocked", ce_in_low, 0);
        check_value("status.pll_state", status.pll_state, exp_opt);
      end
      default: begin
        check_value("stretched level cycles", stretch_seen, stretch_exp);
        check_value("ce during contention", ce_in_cont, 0);
        check_value("level low during contention", level_low_in_cont, 0);
      end
    endcase
    check_value("short plain pulses", short_run, 0);
  endtask

  task automatic run_row(input int r);
    int k;
    int errors_before;
    errors_before = total_errors;
    row_kind      = tbl[r].kind;
    row_div       = divisor_of(tbl[r].turbo);
    row_min_half  = half_period_of(prev_turbo);
    if (half_period_of(tbl[r].turbo) < row_min_half)
      row_min_half = half_period_of(tbl[r].turbo);
    for (k = 0; k < int'(tbl[r].cycles); k++) begin
      @(posedge CLK_OUT1);
      #1;
      if (k == 0) begin
        clear_stats();
        row_active = 1'b1;
      end
      cyc        = k;
      ctrl.turbo = tbl[r].turbo;
      ctrl.pll_option = (k >= int'(tbl[r].option2_at)) ? tbl[r].option2 : tbl[r].option;
      contention = (k >= int'(tbl[r].cont_start)) &&
                   (k < int'(tbl[r].cont_start) + int'(tbl[r].cont_len));
    end
    // Let the last sample land
    @(negedge CLK_OUT1);
    #1;
    row_active = 1'b0;
    evaluate_row(r);
    if (total_errors == errors_before) begin
      pass_count++;
      $display("Test %0d %s: ok", r, kind_name(row_kind));
    end else begin
      fail_count++;
      $display("Test %0d %s: failed with %0d errors", r, kind_name(row_kind),
               total_errors - errors_before);
    end
    prev_turbo = tbl[r].turbo;
  endtask

  initial begin
    void'($urandom(21));
    rst          = 1'b1;
    ctrl         = '0;
    contention   = 1'b0;
    row_active   = 1'b0;
    row_kind     = k_boot;
    row_div      = 8;
    row_min_half = 1;
    cyc          = 0;
    prev_turbo   = turbo_3m5;
    total_errors = 0;
    pass_count   = 0;
    fail_count   = 0;
    sva_failures = 0;
    prev_locked  = 1'b0;
    plain_prev   = 1'b0;
    plain_run    = 0;
    clear_stats();
    fill_table();
    table_ready = 1'b1;
    repeat (4) @(posedge CLK_OUT1);
    #1 rst = 1'b0;
    for (int r = 0; r < num_rows; r++)
      run_row(r);
    // Failures flagged by the bound assertions
    sva_failures = dut.u_pll_lock_model.u_lock_sva.failures +
                   dut.u_cpu_clock_divider.u_clock_sva.failures;
    check_true(sva_failures == 0, "a bound assertion failed during the run");
    $display("Summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
    if (total_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Ends a stuck run, limit follows the table length
  initial begin : watchdog
    int limit_cycles;
    wait (table_ready === 1'b1);
    limit_cycles = 4 + 100;
    for (int r = 0; r < num_rows; r++)
      limit_cycles += int'(tbl[r].cycles) + 2;
    repeat (limit_cycles) @(posedge CLK_OUT1);
    $display("Timeout: run did not finish within %0d cycles", limit_cycles);
    $display("** FAIL **");
    $finish;
  end

endmodule

// ==== all.f ====
src/zxclk_pkg.sv
src/reconf_sequencer.sv
src/pll_lock_model.sv
src/cpu_clock_divider.sv
src/clock_generator.sv
sim/clock_generator_sva.sv
sim/tb_clock_generator.sv

// ==== Bender.yml ====
package:
  name: zx_clock_generator

sources:
  - src/zxclk_pkg.sv
  - src/reconf_sequencer.sv
  - src/pll_lock_model.sv
  - src/cpu_clock_divider.sv
  - src/clock_generator.sv
  - target: simulation
    files:
      - sim/clock_generator_sva.sv
      - sim/tb_clock_generator.sv
